//--- Makefile
# Verilator build and run of the five-stage core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# $$fatal in the testbench makes the simulation binary exit non-zero
test:
	verilator --binary --timing --assert -f compile.f \
		--top-module tb_mips_core -Mdir obj_dir -o Vtb_mips_core
	./obj_dir/Vtb_mips_core

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+.
mips_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_hazard.sv
mips_core.sv
tb_mips_core.sv

//--- mips_alu.sv
// mips_alu: arithmetic, logic, shift and compare unit of the execute stage
`timescale 1ns/100ps

module mips_alu (
   input  logic [mips_pkg::XLEN-1:0]  op_a,
   input  logic [mips_pkg::XLEN-1:0]  op_b,
   input  mips_pkg::alu_op_t          alu_op,
   input  logic [mips_pkg::REG_W-1:0] shamt,
   output logic [mips_pkg::XLEN-1:0]  result,
   output logic                       equal
);

   // variable shift count comes from rs
   logic [mips_pkg::REG_W-1:0] vshamt;

   assign vshamt = op_a[mips_pkg::REG_W-1:0];

   always_comb begin
      case (alu_op)
         mips_pkg::ADD: result = op_a + op_b;
         mips_pkg::SUB: result = op_a - op_b;
         mips_pkg::AND: result = op_a & op_b;
         mips_pkg::OR:  result = op_a | op_b;
         mips_pkg::XOR: result = op_a ^ op_b;
         mips_pkg::NOR: result = ~(op_a | op_b);
         // compares give 0 or 1
         mips_pkg::SLT: begin
            result = {{(mips_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         end
         mips_pkg::SLTU: begin
            result = {{(mips_pkg::XLEN-1){1'b0}}, op_a < op_b};
         end
         // shifts always move rt, which sits on op_b
         mips_pkg::SLL:  result = op_b << shamt;
         mips_pkg::SRL:  result = op_b >> shamt;
         mips_pkg::SRA:  result = $signed(op_b) >>> shamt;
         mips_pkg::SLLV: result = op_b << vshamt;
         mips_pkg::SRLV: result = op_b >> vshamt;
         mips_pkg::SRAV: result = $signed(op_b) >>> vshamt;
         // immediate into the upper half
         mips_pkg::LUI:  result = {op_b[15:0], 16'h0000};
         default:        result = '0;
      endcase
   end

   // beq and bne look only at this
   assign equal = (op_a == op_b);

endmodule

//--- mips_core.sv
// mips_core: five-stage pipelined mips-i subset with forwarding, load-use stall and halt
`timescale 1ns/100ps

module mips_core (
   input  logic        clk,
   input  logic        rst_b,
   input  logic [31:0] inst,
   input  logic [31:0] mem_rdata,
   output logic [29:0] inst_addr,
   output logic [29:0] mem_addr,
   output logic [31:0] mem_wdata,
   output logic [3:0]  mem_wen,
   output logic        halted
);

   localparam int XW = mips_pkg::XLEN;
   localparam int RW = mips_pkg::REG_W;

   // fetch
   logic [XW-1:0] pc;
   logic          halt_fetch;
   // decode
   logic          id_valid, id_halt;
   logic [XW-1:0] id_instr, id_word, id_pc, id_imm, rs_data, rt_data;
   logic [RW-1:0] id_rs, id_rt, id_rd;
   mips_pkg::alu_op_t id_alu_op;
   logic id_use_imm, id_reg_we, id_mem_read, id_mem_write;
   logic id_is_branch, id_branch_ne, id_is_halt, id_reads_rt;
   // execute
   logic ex_valid, ex_reg_we, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_halt;
   logic ex_branch_ne, ex_use_imm, alu_equal, branch_taken;
   mips_pkg::alu_op_t  ex_alu_op;
   mips_pkg::fwd_sel_t fwd_a, fwd_b;
   logic [RW-1:0] ex_rs, ex_rt, ex_rd, ex_shamt;
   logic [XW-1:0] ex_pc, ex_imm, ex_rs_data, ex_rt_data;
   logic [XW-1:0] op_a, fwd_rt, op_b, alu_result, br_target;
   // memory and writeback
   logic mem_valid, mem_reg_we, mem_mem_read, mem_mem_write, mem_is_halt;
   logic wb_valid, wb_reg_we, wb_mem_read, wb_is_halt;
   logic [RW-1:0] mem_rd, wb_rd;
   logic [XW-1:0] mem_alu, mem_sdata, wb_alu, wb_load, wb_data;
   logic stall, flush;

   // same source choice for both execute operands
   function automatic logic [XW-1:0] fwd_mux(input mips_pkg::fwd_sel_t sel,
                                             input logic [XW-1:0] reg_val,
                                             input logic [XW-1:0] mem_val,
                                             input logic [XW-1:0] wb_val);
      case (sel)
         mips_pkg::FWD_MEM: return mem_val;
         mips_pkg::FWD_WB:  return wb_val;
         default:           return reg_val;
      endcase
   endfunction

   // fetch, pc stops once a halt reaches decode
   assign id_halt   = id_valid && id_is_halt;
   assign inst_addr = pc[31:2];
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc         <= mips_pkg::TEXT_START;
         halt_fetch <= 1'b0;
      end else begin
         if (flush) begin
            pc <= br_target;
         end else if (!stall && !id_halt && !halt_fetch) begin
            pc <= pc + 32'd4;
         end
         if (id_halt && !stall && !flush) begin
            halt_fetch <= 1'b1;
         end
      end
   end

   // decode register, held by a stall
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         id_valid <= 1'b0;
      end else if (flush) begin
         id_valid <= 1'b0;
      end else if (!stall) begin
         id_valid <= !(id_halt || halt_fetch);
      end
   end
   always_ff @(posedge clk) begin
      if (!stall) begin
         id_instr <= inst;
         id_pc    <= pc;
      end
   end

   // an empty slot decodes as sll r0, which writes nothing
   assign id_word = id_valid ? id_instr : '0;

   mips_decode i_mips_decode (
      .instr(id_word), .rs(id_rs), .rt(id_rt), .rd(id_rd), .alu_op(id_alu_op),
      .use_imm(id_use_imm), .reg_we(id_reg_we), .mem_read(id_mem_read),
      .mem_write(id_mem_write), .is_branch(id_is_branch), .branch_ne(id_branch_ne),
      .is_halt(id_is_halt), .reads_rt(id_reads_rt), .imm(id_imm)
   );

   mips_regfile i_mips_regfile (
      .clk(clk), .rst_b(rst_b), .rs(id_rs), .rt(id_rt), .wr_reg(wb_rd),
      .wr_data(wb_data), .we(wb_valid && wb_reg_we), .rs_data(rs_data), .rt_data(rt_data)
   );

   // execute register, a bubble on stall or flush
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         {ex_valid, ex_reg_we, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_halt} <= '0;
      end else if (flush || stall) begin
         {ex_valid, ex_reg_we, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_halt} <= '0;
      end else begin
         ex_valid     <= id_valid;
         ex_reg_we    <= id_reg_we;
         ex_mem_read  <= id_mem_read;
         ex_mem_write <= id_mem_write;
         ex_is_branch <= id_is_branch;
         ex_is_halt   <= id_is_halt;
      end
   end
   always_ff @(posedge clk) begin
      ex_alu_op    <= id_alu_op;
      ex_use_imm   <= id_use_imm;
      ex_branch_ne <= id_branch_ne;
      ex_rs        <= id_rs;
      ex_rt        <= id_rt;
      ex_rd        <= id_rd;
      ex_shamt     <= id_word[10:6];
      ex_pc        <= id_pc;
      ex_imm       <= id_imm;
      ex_rs_data   <= rs_data;
      ex_rt_data   <= rt_data;
   end

   mips_hazard i_mips_hazard (
      .id_rs(id_rs), .id_rt(id_rt), .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_rd(ex_rd),
      .mem_rd(mem_rd), .wb_rd(wb_rd), .id_reads_rt(id_reads_rt), .ex_reg_we(ex_reg_we),
      .ex_mem_read(ex_mem_read), .mem_reg_we(mem_reg_we), .wb_reg_we(wb_reg_we),
      .branch_taken(branch_taken), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
   );

   assign op_a   = fwd_mux(fwd_a, ex_rs_data, mem_alu, wb_data);
   assign fwd_rt = fwd_mux(fwd_b, ex_rt_data, mem_alu, wb_data);
   assign op_b   = ex_use_imm ? ex_imm : fwd_rt;

   mips_alu i_mips_alu (
      .op_a(op_a), .op_b(op_b), .alu_op(ex_alu_op), .shamt(ex_shamt),
      .result(alu_result), .equal(alu_equal)
   );

   // branch resolves here, no delay slot
   assign branch_taken = ex_valid && ex_is_branch && (alu_equal ^ ex_branch_ne);
   assign br_target    = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};

   // memory stage drives the data port
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         {mem_valid, mem_reg_we, mem_mem_read, mem_mem_write, mem_is_halt} <= '0;
      end else begin
         {mem_valid, mem_reg_we, mem_mem_read, mem_mem_write, mem_is_halt} <=
            {ex_valid, ex_reg_we, ex_mem_read, ex_mem_write, ex_is_halt};
      end
   end
   always_ff @(posedge clk) begin
      mem_rd    <= ex_rd;
      mem_alu   <= alu_result;
      mem_sdata <= fwd_rt;
   end
   assign mem_addr  = mem_alu[31:2];
   assign mem_wdata = mem_sdata;
   assign mem_wen   = {4{mem_valid && mem_mem_write}};

   // writeback, halted rises as the halt leaves this stage
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         {wb_valid, wb_reg_we, wb_mem_read, wb_is_halt, halted} <= '0;
      end else begin
         {wb_valid, wb_reg_we, wb_mem_read, wb_is_halt} <=
            {mem_valid, mem_reg_we, mem_mem_read, mem_is_halt};
         halted <= halted || (wb_valid && wb_is_halt);
      end
   end
   always_ff @(posedge clk) begin
      wb_rd   <= mem_rd;
      wb_alu  <= mem_alu;
      wb_load <= mem_rdata;
   end
   assign wb_data = wb_mem_read ? wb_load : wb_alu;

   // word stores only, and nothing reaches memory after the halt drains
   a_store_mask: assert property (
      @(posedge clk) disable iff (!rst_b)
      ((mem_wen == 4'h0) || (mem_wen == 4'hf)) && (halted -> (mem_wen == 4'h0))
   );

endmodule

//--- mips_decode.sv
// mips_decode: field split, control generation and immediate extension of one instruction
`timescale 1ns/100ps

module mips_decode (
   input  logic [mips_pkg::XLEN-1:0]  instr,
   output logic [mips_pkg::REG_W-1:0] rs,
   output logic [mips_pkg::REG_W-1:0] rt,
   output logic [mips_pkg::REG_W-1:0] rd,
   output mips_pkg::alu_op_t          alu_op,
   output logic                       use_imm,
   output logic                       reg_we,
   output logic                       mem_read,
   output logic                       mem_write,
   output logic                       is_branch,
   output logic                       branch_ne,
   output logic                       is_halt,
   output logic                       reads_rt,
   output logic [mips_pkg::XLEN-1:0]  imm
);

   logic [5:0]  opcode;
   logic [5:0]  funct;
   logic [15:0] imm16;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];
   assign imm16  = instr[15:0];
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];

   always_comb begin
      // defaults give a no-op, anything unknown stays that way
      rd        = '0;
      alu_op    = mips_pkg::ADD;
      use_imm   = 1'b0;
      reg_we    = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      is_branch = 1'b0;
      branch_ne = 1'b0;
      is_halt   = 1'b0;
      reads_rt  = 1'b0;
      // sign extension serves arithmetic, compare, memory and branch offsets
      imm       = {{16{imm16[15]}}, imm16};
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            rd       = instr[15:11];
            reg_we   = 1'b1;
            reads_rt = 1'b1;
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::XOR;
               mips_pkg::FN_NOR:  alu_op = mips_pkg::NOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::SLT;
               mips_pkg::FN_SLTU: alu_op = mips_pkg::SLTU;
               mips_pkg::FN_SLL:  alu_op = mips_pkg::SLL;
               mips_pkg::FN_SRL:  alu_op = mips_pkg::SRL;
               mips_pkg::FN_SRA:  alu_op = mips_pkg::SRA;
               mips_pkg::FN_SLLV: alu_op = mips_pkg::SLLV;
               mips_pkg::FN_SRLV: alu_op = mips_pkg::SRLV;
               mips_pkg::FN_SRAV: alu_op = mips_pkg::SRAV;
               mips_pkg::FN_SYSCALL: begin
                  reg_we   = 1'b0;
                  reads_rt = 1'b0;
                  is_halt  = 1'b1;
               end
               default: begin
                  reg_we   = 1'b0;
                  reads_rt = 1'b0;
               end
            endcase
         end
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
            // compare happens on the alu equal output
            is_branch = 1'b1;
            branch_ne = (opcode == mips_pkg::OP_BNE);
            reads_rt  = 1'b1;
            alu_op    = mips_pkg::SUB;
         end
         mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
            // immediate forms write rt
            rd      = rt;
            reg_we  = 1'b1;
            use_imm = 1'b1;
            case (opcode)
               mips_pkg::OP_SLTI:  alu_op = mips_pkg::SLT;
               mips_pkg::OP_SLTIU: alu_op = mips_pkg::SLTU;
               mips_pkg::OP_ANDI:  alu_op = mips_pkg::AND;
               mips_pkg::OP_ORI:   alu_op = mips_pkg::OR;
               mips_pkg::OP_XORI:  alu_op = mips_pkg::XOR;
               mips_pkg::OP_LUI:   alu_op = mips_pkg::LUI;
               default:            alu_op = mips_pkg::ADD;
            endcase
            // logical immediates are zero extended
            if (opcode == mips_pkg::OP_ANDI || opcode == mips_pkg::OP_ORI ||
                opcode == mips_pkg::OP_XORI) begin
               imm = {16'h0000, imm16};
            end
         end
         mips_pkg::OP_LW: begin
            rd       = rt;
            reg_we   = 1'b1;
            use_imm  = 1'b1;
            mem_read = 1'b1;
         end
         mips_pkg::OP_SW: begin
            use_imm   = 1'b1;
            mem_write = 1'b1;
            reads_rt  = 1'b1;
         end
         default: begin
            rd = '0;
         end
      endcase
   end

endmodule

//--- mips_hazard.sv
// mips_hazard: forwarding selects, load-use stall and taken-branch flush of the pipeline
`timescale 1ns/100ps

module mips_hazard (
   input  logic [mips_pkg::REG_W-1:0] id_rs,
   input  logic [mips_pkg::REG_W-1:0] id_rt,
   input  logic [mips_pkg::REG_W-1:0] ex_rs,
   input  logic [mips_pkg::REG_W-1:0] ex_rt,
   input  logic [mips_pkg::REG_W-1:0] ex_rd,
   input  logic [mips_pkg::REG_W-1:0] mem_rd,
   input  logic [mips_pkg::REG_W-1:0] wb_rd,
   input  logic                       id_reads_rt,
   input  logic                       ex_reg_we,
   input  logic                       ex_mem_read,
   input  logic                       mem_reg_we,
   input  logic                       wb_reg_we,
   input  logic                       branch_taken,
   output mips_pkg::fwd_sel_t         fwd_a,
   output mips_pkg::fwd_sel_t         fwd_b,
   output logic                       stall,
   output logic                       flush
);

   logic load_use;

   // memory stage is younger, so it wins over writeback
   function automatic mips_pkg::fwd_sel_t pick_src(input logic [mips_pkg::REG_W-1:0] src);
      mips_pkg::fwd_sel_t sel;
      sel = mips_pkg::FWD_NONE;
      if (src != '0) begin
         if (mem_reg_we && mem_rd == src) begin
            sel = mips_pkg::FWD_MEM;
         end else if (wb_reg_we && wb_rd == src) begin
            sel = mips_pkg::FWD_WB;
         end
      end
      return sel;
   endfunction

   assign fwd_a = pick_src(ex_rs);
   assign fwd_b = pick_src(ex_rt);

   // load result is not ready until writeback
   // rs is always treated as read, rt only where the instruction uses it
   assign load_use = ex_mem_read && ex_reg_we && (ex_rd != '0) &&
                     ((id_rs == ex_rd) || (id_reads_rt && (id_rt == ex_rd)));

   // the branch kills the waiting instruction anyway
   assign stall = load_use && !branch_taken;
   assign flush = branch_taken;

endmodule

//--- mips_pkg.sv
// mips_pkg: widths, reset address, instruction encodings and enums of the five-stage core
package mips_pkg;

   // datapath and register file sizes
   localparam int XLEN     = 32;
   localparam int REG_W    = 5;
   localparam int NUM_REGS = 32;

   // byte address of the first fetch after reset
   localparam logic [XLEN-1:0] TEXT_START = 32'h0040_0000;

   // primary opcodes, instr[31:26]
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_BNE   = 6'h05;
   localparam logic [5:0] OP_ADDIU = 6'h09;
   localparam logic [5:0] OP_SLTI  = 6'h0a;
   localparam logic [5:0] OP_SLTIU = 6'h0b;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;
   localparam logic [5:0] OP_XORI  = 6'h0e;
   localparam logic [5:0] OP_LUI   = 6'h0f;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   // funct codes of the r-type group, instr[5:0]
   localparam logic [5:0] FN_SLL     = 6'h00;
   localparam logic [5:0] FN_SRL     = 6'h02;
   localparam logic [5:0] FN_SRA     = 6'h03;
   localparam logic [5:0] FN_SLLV    = 6'h04;
   localparam logic [5:0] FN_SRLV    = 6'h06;
   localparam logic [5:0] FN_SRAV    = 6'h07;
   // syscall doubles as the halt instruction
   localparam logic [5:0] FN_SYSCALL = 6'h0c;
   localparam logic [5:0] FN_ADDU    = 6'h21;
   localparam logic [5:0] FN_SUBU    = 6'h23;
   localparam logic [5:0] FN_AND     = 6'h24;
   localparam logic [5:0] FN_OR      = 6'h25;
   localparam logic [5:0] FN_XOR     = 6'h26;
   localparam logic [5:0] FN_NOR     = 6'h27;
   localparam logic [5:0] FN_SLT     = 6'h2a;
   localparam logic [5:0] FN_SLTU    = 6'h2b;

   // alu operations, carried from decode into execute
   typedef enum logic [3:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      NOR,
      SLT,
      SLTU,
      SLL,
      SRL,
      SRA,
      SLLV,
      SRLV,
      SRAV,
      LUI
   } alu_op_t;

   // execute operand source
   typedef enum logic [1:0] {
      FWD_NONE = 2'b00,
      FWD_MEM  = 2'b01,
      FWD_WB   = 2'b10
   } fwd_sel_t;

endpackage

//--- mips_regfile.sv
// mips_regfile: 32 general registers with two read ports, one write port and r0 fixed at zero
`timescale 1ns/100ps

module mips_regfile (
   input  logic                       clk,
   input  logic                       rst_b,
   input  logic [mips_pkg::REG_W-1:0] rs,
   input  logic [mips_pkg::REG_W-1:0] rt,
   input  logic [mips_pkg::REG_W-1:0] wr_reg,
   input  logic [mips_pkg::XLEN-1:0]  wr_data,
   input  logic                       we,
   output logic [mips_pkg::XLEN-1:0]  rs_data,
   output logic [mips_pkg::XLEN-1:0]  rt_data
);

   logic [mips_pkg::XLEN-1:0] regs [mips_pkg::NUM_REGS];

   // writeback port, r0 is cleared by reset and never stored
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         regs[0] <= '0;
      end else if (we && wr_reg != '0) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // read in decode, a same-cycle writeback wins over the stored word
   assign rs_data = (we && wr_reg != '0 && wr_reg == rs) ? wr_data : regs[rs];
   assign rt_data = (we && wr_reg != '0 && wr_reg == rt) ? wr_data : regs[rt];

   // r0 reads zero on both ports, even while a write to r0 is pending
   a_r0_zero: assert property (
      @(posedge clk) disable iff (!rst_b)
      ((rs == '0) -> (rs_data == '0)) && ((rt == '0) -> (rt_data == '0))
   );

endmodule

//--- tb_mips_model.svh
// tb_mips_model: random program generator and instruction-level reference model of the core
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

// lcg step, high half folded into the low bits for better spread
function automatic logic [31:0] next_rand();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state ^ {16'h0000, lcg_state[31:16]};
endfunction

function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh);
   return {mips_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm16);
   return {op, rs, rt, imm16};
endfunction

// one of the fourteen r-type alu functs
function automatic logic [5:0] pick_funct(input logic [3:0] sel);
   case (int'(sel) % 14)
      0:       return mips_pkg::FN_ADDU;
      1:       return mips_pkg::FN_SUBU;
      2:       return mips_pkg::FN_AND;
      3:       return mips_pkg::FN_OR;
      4:       return mips_pkg::FN_XOR;
      5:       return mips_pkg::FN_NOR;
      6:       return mips_pkg::FN_SLT;
      7:       return mips_pkg::FN_SLTU;
      8:       return mips_pkg::FN_SLL;
      9:       return mips_pkg::FN_SRL;
      10:      return mips_pkg::FN_SRA;
      11:      return mips_pkg::FN_SLLV;
      12:      return mips_pkg::FN_SRLV;
      default: return mips_pkg::FN_SRAV;
   endcase
endfunction

// immediate-group opcode, addiu gets the spare code
function automatic logic [5:0] pick_iop(input logic [2:0] sel);
   case (sel)
      3'd1:    return mips_pkg::OP_SLTI;
      3'd2:    return mips_pkg::OP_SLTIU;
      3'd3:    return mips_pkg::OP_ANDI;
      3'd4:    return mips_pkg::OP_ORI;
      3'd5:    return mips_pkg::OP_XORI;
      3'd6:    return mips_pkg::OP_LUI;
      default: return mips_pkg::OP_ADDIU;
   endcase
endfunction

// prologue loads r1..r15, random body, then the result stores and the halt
task automatic build_program();
   int          n;
   int          off;
   int          maxoff;
   logic [31:0] r;
   logic [31:0] v;
   n = 0;
   for (int k = 0; k < IMEM_WORDS; k++) begin
      imem[k[6:0]] = '0;
   end
   for (int k = 1; k < 16; k++) begin
      v = next_rand();
      imem[n[6:0]] = encode_i(mips_pkg::OP_LUI, 5'd0, k[4:0], v[31:16]);
      imem[n[6:0] + 7'd1] = encode_i(mips_pkg::OP_ORI, k[4:0], k[4:0], v[15:0]);
      n = n + 2;
   end
   for (int i = 0; i < BODY_LEN; i++) begin
      r = next_rand();
      case (r[31:29])
         3'd0, 3'd1, 3'd2: begin
            imem[n[6:0]] = encode_r(pick_funct(r[11:8]), {1'b0, r[3:0]}, {1'b0, r[7:4]},
                                    {1'b0, r[15:12]}, r[20:16]);
         end
         3'd3, 3'd4: begin
            v = next_rand();
            imem[n[6:0]] = encode_i(pick_iop(r[14:12]), {1'b0, r[3:0]}, {1'b0, r[7:4]},
                                    v[15:0]);
         end
         3'd5, 3'd6: begin
            // word-aligned offset, base is any register
            v = next_rand();
            imem[n[6:0]] = encode_i(r[28] ? mips_pkg::OP_SW : mips_pkg::OP_LW,
                                    {1'b0, r[3:0]}, {1'b0, r[7:4]}, {v[15:2], 2'b00});
         end
         default: begin
            // forward only, never past the first result store
            maxoff = PRO_LEN + BODY_LEN - n - 1;
            off    = 1 + int'(r[17:16]);
            if (off > maxoff) begin
               off = maxoff;
            end
            imem[n[6:0]] = encode_i(r[28] ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ,
                                    {1'b0, r[3:0]}, r[8] ? {1'b0, r[3:0]} : {1'b0, r[7:4]},
                                    off[15:0]);
         end
      endcase
      n = n + 1;
   end
   for (int k = 1; k < 16; k++) begin
      imem[n[6:0]] = encode_i(mips_pkg::OP_SW, 5'd0, k[4:0], 16'((SLOT_BASE + k) * 4));
      n = n + 1;
   end
   imem[n[6:0]] = encode_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0);
endtask
`endif

//--- tb_mips_core.sv
// tb_mips_core: random-program testbench of the core against an instruction-level model
`timescale 1ns/100ps

module tb_mips_core;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_PROGS    = 3;
   // 15 lui/ori pairs, random body, 15 stores and the halt
   localparam int PRO_LEN      = 30;
   localparam int BODY_LEN     = 48;
   localparam int PROG_LEN     = PRO_LEN + BODY_LEN + 16;
   localparam int IMEM_WORDS   = 128;
   localparam int DMEM_WORDS   = 64;
   localparam int SLOT_BASE    = 48;
   localparam int DRAIN_CYCLES = 8;
   localparam int LIMIT_CYCLES = NUM_PROGS * (3 * PROG_LEN + 100 + RESET_CYCLES + DRAIN_CYCLES);
   localparam logic [31:0] SEED      = 32'd7072;
   localparam logic [29:0] TEXT_WORD = mips_pkg::TEXT_START[31:2];

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [31:0] mem_rdata;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [3:0]  mem_wen;
   logic        halted;

   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] dmem [DMEM_WORDS];
   logic [29:0] imem_idx;
   logic [31:0] lcg_state;
   // expected stores in program order, filled by the model
   logic [29:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          store_count;

   `include "tb_mips_model.svh"

   mips_core i_mips_core (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wen(mem_wen), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // both memories answer in the same cycle
   assign imem_idx = inst_addr - TEXT_WORD;
   always_comb begin
      inst      = (imem_idx[29:7] == '0) ? imem[imem_idx[6:0]] : '0;
      mem_rdata = dmem[mem_addr[5:0]];
   end

   task automatic stop_on_error();
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
         stop_on_error();
      end
   endtask

   // walk the program in order, 64-word data memory aliased on byte address bits 7:2
   task automatic run_reference();
      logic [31:0] gpr [32];
      logic [31:0] mdl_mem [DMEM_WORDS];
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_s;
      logic [31:0] addr;
      logic [31:0] res;
      logic        wr;
      logic [4:0]  dst;
      int          pc;
      exp_addr.delete();
      exp_data.delete();
      for (int k = 0; k < 32; k++) begin
         gpr[k[4:0]] = '0;
      end
      for (int k = 0; k < DMEM_WORDS; k++) begin
         mdl_mem[k[5:0]] = '0;
      end
      pc = 0;
      while (pc < IMEM_WORDS &&
             !(imem[pc[6:0]][31:26] == mips_pkg::OP_RTYPE &&
               imem[pc[6:0]][5:0] == mips_pkg::FN_SYSCALL)) begin
         w     = imem[pc[6:0]];
         a     = gpr[w[25:21]];
         b     = gpr[w[20:16]];
         imm_s = {{16{w[15]}}, w[15:0]};
         addr  = a + imm_s;
         wr    = 1'b1;
         dst   = w[20:16];
         res   = '0;
         pc    = pc + 1;
         case (w[31:26])
            mips_pkg::OP_RTYPE: begin
               dst = w[15:11];
               case (w[5:0])
                  mips_pkg::FN_ADDU: res = a + b;
                  mips_pkg::FN_SUBU: res = a - b;
                  mips_pkg::FN_AND:  res = a & b;
                  mips_pkg::FN_OR:   res = a | b;
                  mips_pkg::FN_XOR:  res = a ^ b;
                  mips_pkg::FN_NOR:  res = ~(a | b);
                  mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  mips_pkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                  mips_pkg::FN_SLL:  res = b << w[10:6];
                  mips_pkg::FN_SRL:  res = b >> w[10:6];
                  mips_pkg::FN_SRA:  res = $signed(b) >>> w[10:6];
                  mips_pkg::FN_SLLV: res = b << a[4:0];
                  mips_pkg::FN_SRLV: res = b >> a[4:0];
                  mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                  default:           wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDIU: res = a + imm_s;
            mips_pkg::OP_SLTI:  res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            mips_pkg::OP_SLTIU: res = (a < imm_s) ? 32'd1 : 32'd0;
            mips_pkg::OP_ANDI:  res = a & {16'h0000, w[15:0]};
            mips_pkg::OP_ORI:   res = a | {16'h0000, w[15:0]};
            mips_pkg::OP_XORI:  res = a ^ {16'h0000, w[15:0]};
            mips_pkg::OP_LUI:   res = {w[15:0], 16'h0000};
            mips_pkg::OP_LW:    res = mdl_mem[addr[7:2]];
            mips_pkg::OP_SW: begin
               wr = 1'b0;
               mdl_mem[addr[7:2]] = b;
               exp_addr.push_back(addr[31:2]);
               exp_data.push_back(b);
            end
            default: begin
               // beq and bne, target counted from the next instruction
               wr = 1'b0;
               if ((a == b) != (w[31:26] == mips_pkg::OP_BNE)) begin
                  pc = pc + int'($signed(w[15:0]));
               end
            end
         endcase
         if (wr && dst != 5'd0) begin
            gpr[dst] = res;
         end
      end
   endtask

   // store checker and data memory, sampled mid-cycle where the port is stable
   initial begin
      store_count = 0;
      for (int k = 0; k < DMEM_WORDS; k++) begin
         dmem[k[5:0]] = '0;
      end
      forever begin
         @(negedge clk);
         if (!rst_b) begin
            store_count = 0;
            for (int k = 0; k < DMEM_WORDS; k++) begin
               dmem[k[5:0]] = '0;
            end
         end else if (mem_wen != 4'h0) begin
            if (halted) begin
               $display("error at %0t: store issued after the core halted", $time);
               stop_on_error();
            end
            if (store_count >= exp_addr.size()) begin
               $display("error at %0t: more stores than the model expects", $time);
               stop_on_error();
            end
            check_value({2'b00, mem_addr}, {2'b00, exp_addr[store_count]}, "store address");
            check_value(mem_wdata, exp_data[store_count], "store data");
            dmem[mem_addr[5:0]] = mem_wdata;
            store_count = store_count + 1;
         end
      end
   end

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("error: timeout, the core did not halt within %0d cycles", LIMIT_CYCLES);
      stop_on_error();
   end

   task automatic apply_reset();
      @(negedge clk);
      rst_b = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_b = 1'b1;
   endtask

   initial begin
      rst_b     = 1'b0;
      lcg_state = SEED;
      for (int p = 0; p < NUM_PROGS; p++) begin
         build_program();
         run_reference();
         apply_reset();
         // first fetch and idle outputs before the first edge out of reset
         check_value({28'h0, mem_wen}, 32'h0, "mem_wen after reset");
         check_value({31'h0, halted}, 32'h0, "halted after reset");
         check_value({2'b00, inst_addr}, {2'b00, TEXT_WORD}, "first fetch address");
         while (halted !== 1'b1) begin
            @(negedge clk);
         end
         check_value(32'(store_count), 32'(exp_addr.size()), "store count at halt");
         // any store in this window trips the checker
         repeat (DRAIN_CYCLES) @(negedge clk);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule
